/* verification/adcStim.txt */
// Each line holds a converter word in hex, its OTR bit and an end of run marker
// The first three lines of every run are pipeline fill and never come out
0AA 0 0
FFF 1 0
123 0 0
400 0 0
7FF 0 0
801 0 0
C3F 0 1
010 1 0
FF0 1 0
222 0 0
FFE 1 0
803 1 0
7FF 1 0
001 1 0
555 0 0
9A9 1 1

/* vlog.f */
rtl/adcPkg.sv
rtl/adcSequencer.sv
rtl/adcClockGen.sv
rtl/adcCapture.sv
rtl/sampleAverager.sv
rtl/adcFrontEnd.sv
verification/adcClockSource.sv
verification/adcFrontEndTb.sv

/* run.sh */
#!/bin/sh
# Builds the ADC front end testbench with Verilator and runs it

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module adcFrontEndTb -o simv
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -q "TESTS FAILED" "$LOG"; then
  exit 1
fi
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi
exit 0

/* verification/adcFrontEndTb.sv */
// ================================================
// Testbench for the ADC acquisition front end
// Replays converter words from the stim file and checks
// samples, averages, OTR count and the converter clock
// ================================================
`timescale 1ns/1ps

module adcFrontEndTb import adcPkg::*; ();

  localparam int AvgLog2    = 2;               // Same block length as the DUT
  localparam int BlockLen   = 1 << AvgLog2;
  localparam int MaxEntries = 64;
  localparam int RiseLimit  = 3 * ClkDivide;   // Cycles allowed between AdcClk rises

  logic                   Clk;
  logic                   reset_n;
  logic                   Start;
  logic                   AdcClk;
  logic                   SampleValid;
  logic                   AverageValid;
  adcSample_t             Adc;
  adcSample_t             Sample;
  logic [SampleWidth-1:0] Average;
  logic [7:0]             OtrCount;

  adcSample_t             stimWord [MaxEntries];
  logic                   stimEnd [MaxEntries];   // Last entry of a run
  int                     numEntries;
  adcSample_t             expSamples [$];
  logic [SampleWidth-1:0] expAverages [$];
  adcSample_t             expSample;
  logic [7:0]             modelOtr;               // Reference OTR count, saturating
  logic [31:0]            lcgState;
  logic                   lastAdcClk;
  bit                     haveRise;
  int                     runIndex;
  int                     sinceRise;
  int                     idleCycles;

  adcClockSource #(.PeriodNs(10)) i_adcClockSource (.Clk(Clk));

  adcFrontEnd #(
    .AvgLog2 (AvgLog2)
  ) i_adcFrontEnd (
    .Clk          (Clk),
    .reset_n      (reset_n),
    .Start        (Start),
    .Adc          (Adc),
    .AdcClk       (AdcClk),
    .Sample       (Sample),
    .SampleValid  (SampleValid),
    .Average      (Average),
    .AverageValid (AverageValid),
    .OtrCount     (OtrCount)
  );

  task automatic reportFailure(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic checkSample(input string name, input adcSample_t expected,
                             input adcSample_t actual);
    if (actual !== expected)
      reportFailure($sformatf("Mismatch %s expected otr=%0b data=%h actual otr=%0b data=%h",
                              name, expected.otr, expected.data, actual.otr, actual.data));
  endtask

  task automatic checkAverage(input string name, input logic [SampleWidth-1:0] expected,
                              input logic [SampleWidth-1:0] actual);
    if (actual !== expected)
      reportFailure($sformatf("Mismatch %s expected %h actual %h", name, expected, actual));
  endtask

  task automatic checkCount(input string name, input logic [7:0] expected,
                            input logic [7:0] actual);
    if (actual !== expected)
      reportFailure($sformatf("Mismatch %s expected %0d actual %0d", name, expected, actual));
  endtask

  task automatic checkPeriod(input string name, input int expected, input int actual);
    if (actual != expected)
      reportFailure($sformatf("Mismatch %s expected %0d actual %0d", name, expected, actual));
  endtask

  function automatic logic [31:0] nextRandom(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Out of range words go to the rail named by their MSB
  function automatic adcSample_t clampWord(input adcSample_t word);
    adcSample_t result;
    result = word;
    if (word.otr)
      result.data = word.data[SampleWidth-1] ? {SampleWidth{1'b1}} : {SampleWidth{1'b0}};
    return result;
  endfunction

  task automatic loadStim();
    int          fd;
    int          code;
    string       line;
    logic [31:0] wordVal;
    logic [31:0] otrVal;
    logic [31:0] endVal;
    fd = $fopen("verification/adcStim.txt", "r");
    if (fd == 0)
      reportFailure("Cannot open verification/adcStim.txt");
    numEntries = 0;
    while (!$feof(fd) && numEntries < MaxEntries) begin
      code = $fgets(line, fd);
      if (code > 0 && $sscanf(line, "%h %h %h", wordVal, otrVal, endVal) == 3) begin
        stimWord[numEntries].otr  = otrVal[0];
        stimWord[numEntries].data = wordVal[SampleWidth-1:0];
        stimEnd[numEntries]       = endVal[0];
        numEntries++;
      end
    end
    $fclose(fd);
    if (numEntries == 0 || !stimEnd[numEntries - 1])
      reportFailure("Stim file is empty or its last run has no end marker");
  endtask

  // Reference model for one run of entries first..last
  task automatic expectRun(input int first, input int last);
    adcSample_t word;
    int         sum;
    int         count;
    sum   = 0;
    count = 0;
    for (int i = first + AdcPipeDelay; i <= last; i++) begin  // Pipeline fill never shows
      word = clampWord(stimWord[i]);
      expSamples.push_back(word);
      sum += int'(word.data);
      count++;
      if (count == BlockLen) begin
        expAverages.push_back(SampleWidth'(sum / BlockLen));  // Truncated mean
        sum   = 0;
        count = 0;
      end
    end  // A partial block is dropped at the stop
  endtask

  // Converter model, one entry per AdcClk rise, Start drops one period after the last
  task automatic driveRun(input int first, input int last);
    int idx;
    int waitCycles;
    bit stopped;
    bit rose;
    bit prevClk;
    idx     = first;
    stopped = 1'b0;
    prevClk = AdcClk;
    Start   = 1'b1;
    while (!stopped) begin
      waitCycles = 0;
      rose       = 1'b0;
      while (!rose) begin
        @(posedge Clk);
        #1;
        waitCycles++;
        rose    = AdcClk && !prevClk;
        prevClk = AdcClk;
        if (!rose && waitCycles > RiseLimit)
          reportFailure($sformatf("Run %0d saw no AdcClk rise in time", runIndex));
      end
      if (idx > last) begin
        Start   = 1'b0;
        stopped = 1'b1;
      end else begin
        Adc = stimWord[idx];
        idx++;
      end
    end
  endtask

  // Monitor on the falling edge, away from both DUT and driver updates
  always @(negedge Clk) begin
    idleCycles = Start ? 0 : idleCycles + 1;
    if (idleCycles >= 2 && AdcClk !== 1'b0)
      reportFailure("AdcClk is not low while Start is low");
    sinceRise++;
    if (AdcClk && !lastAdcClk) begin
      if (haveRise)
        checkPeriod($sformatf("run %0d AdcClk period", runIndex), ClkDivide, sinceRise);
      haveRise  = 1'b1;
      sinceRise = 0;
    end
    if (!Start)
      haveRise = 1'b0;  // Next run starts a fresh period count
    lastAdcClk = AdcClk;
    if (SampleValid) begin
      if (expSamples.size() == 0)
        reportFailure($sformatf("SampleValid with no sample expected in run %0d", runIndex));
      expSample = expSamples.pop_front();
      checkSample($sformatf("run %0d sample", runIndex), expSample, Sample);
      if (expSample.otr && modelOtr != 8'hFF)
        modelOtr++;
      checkCount($sformatf("run %0d OtrCount", runIndex), modelOtr, OtrCount);
    end
    if (AverageValid) begin
      if (expAverages.size() == 0)
        reportFailure($sformatf("AverageValid with no average expected in run %0d", runIndex));
      checkAverage($sformatf("run %0d average", runIndex), expAverages.pop_front(), Average);
    end
  end

  initial begin
    int passes;
    int otrPerPass;
    int first;
    int gap;
    Start      = 1'b0;
    reset_n    = 1'b0;
    Adc        = '0;
    modelOtr   = 8'd0;
    lcgState   = 32'h17d;
    lastAdcClk = 1'b0;
    haveRise   = 1'b0;
    runIndex   = 0;
    sinceRise  = 0;
    idleCycles = 0;
    loadStim();
    otrPerPass = 0;
    first      = 0;
    for (int i = 0; i < numEntries; i++) begin
      if (i - first >= AdcPipeDelay && stimWord[i].otr)
        otrPerPass++;
      if (stimEnd[i]) begin
        if (i - first < AdcPipeDelay)
          reportFailure("A stim run is shorter than the pipeline delay");
        first = i + 1;
      end
    end
    if (otrPerPass == 0)
      reportFailure("Stim file has no captured OTR entry");
    passes = 255 / otrPerPass + 2;  // Enough replays to saturate OtrCount

    repeat (10) @(posedge Clk);
    #1;
    reset_n = 1'b1;
    if (AdcClk !== 1'b0 || SampleValid !== 1'b0 || AverageValid !== 1'b0)
      reportFailure("Outputs are not idle after reset");
    checkCount("reset OtrCount", 8'd0, OtrCount);

    for (int p = 0; p < passes; p++) begin
      first = 0;
      for (int i = 0; i < numEntries; i++) begin
        if (stimEnd[i]) begin
          runIndex++;
          expectRun(first, i);
          driveRun(first, i);
          lcgState = nextRandom(lcgState);
          gap = 3 + int'(lcgState % 32'd8);
          repeat (gap) @(posedge Clk);
          #1;
          if (expSamples.size() != 0 || expAverages.size() != 0)
            reportFailure($sformatf("Run %0d stopped with outputs still missing", runIndex));
          first = i + 1;
        end
      end
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* verification/adcClockSource.sv */
// ================================================
// Testbench clock source
// Free running system clock for the ADC front end
// ================================================
`timescale 1ns/1ps

module adcClockSource #(
  parameter int PeriodNs = 10
) (
  output logic Clk
);

  initial Clk = 1'b0;

  always #(PeriodNs / 2) Clk = ~Clk;  // 50 percent duty

endmodule

/* rtl/adcFrontEnd.sv */
// ================================================
// ADC acquisition front end, top level
// Sequencer, converter clock, capture and averager
// ================================================
`timescale 1ns/1ps

module adcFrontEnd import adcPkg::*; #(
  parameter int AvgLog2 = 2   // Averaging block is 2^AvgLog2 samples
) (
  input  logic                   Clk,
  input  logic                   reset_n,
  input  logic                   Start,         // Level, acquire while high
  input  adcSample_t             Adc,           // Converter DATA and OTR pins
  output logic                   AdcClk,        // Converter clock, Clk / ClkDivide
  output adcSample_t             Sample,
  output logic                   SampleValid,
  output logic [SampleWidth-1:0] Average,
  output logic                   AverageValid,
  output logic [7:0]             OtrCount
);

  logic clockRun;
  logic clockFall;
  logic captureStrobe;
  logic flush;

  adcSequencer i_adcSequencer (
    .Clk           (Clk),
    .reset_n       (reset_n),
    .Start         (Start),
    .ClockFall     (clockFall),
    .ClockRun      (clockRun),
    .CaptureStrobe (captureStrobe),
    .Flush         (flush)
  );

  adcClockGen i_adcClockGen (
    .Clk       (Clk),
    .reset_n   (reset_n),
    .Run       (clockRun),
    .AdcClk    (AdcClk),
    .ClockFall (clockFall)
  );

  adcCapture i_adcCapture (
    .Clk         (Clk),
    .reset_n     (reset_n),
    .Strobe      (captureStrobe),
    .Adc         (Adc),
    .Sample      (Sample),
    .SampleValid (SampleValid),
    .OtrCount    (OtrCount)
  );

  // Averages the clamped words straight off the capture stage
  sampleAverager #(
    .AvgLog2 (AvgLog2)
  ) i_sampleAverager (
    .Clk          (Clk),
    .reset_n      (reset_n),
    .Flush        (flush),
    .Sample       (Sample),
    .SampleValid  (SampleValid),
    .Average      (Average),
    .AverageValid (AverageValid)
  );

endmodule

/* rtl/sampleAverager.sv */
// ================================================
// Block averager
// Sums 2^AvgLog2 valid samples, emits the truncated
// mean and starts over; Flush drops a partial block
// ================================================
`timescale 1ns/1ps

module sampleAverager import adcPkg::*; #(
  parameter int AvgLog2 = 2   // log2 of block length, at least 1
) (
  input  logic                   Clk,
  input  logic                   reset_n,
  input  logic                   Flush,         // From the sequencer on stop
  input  adcSample_t             Sample,        // Already clamped
  input  logic                   SampleValid,
  output logic [SampleWidth-1:0] Average,       // Truncated mean
  output logic                   AverageValid   // One cycle after the last sample
);

  localparam int AccWidth = SampleWidth + AvgLog2;  // No overflow over one block

  logic [AccWidth-1:0] acc;
  logic [AccWidth-1:0] sum;
  logic [AvgLog2-1:0]  count;  // Samples already in acc
  logic                lastSample;

  assign sum        = acc + AccWidth'(Sample.data);
  assign lastSample = &count;

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      acc          <= '0;
      count        <= '0;
      AverageValid <= 1'b0;
    end else if (Flush) begin
      acc          <= '0;   // Partial block is lost
      count        <= '0;
      AverageValid <= 1'b0;
    end else begin
      AverageValid <= SampleValid && lastSample;
      if (SampleValid) begin
        acc   <= lastSample ? '0 : sum;
        count <= count + 1'b1;  // Wraps to zero after the last one
      end
    end
  end

  // Divide by the block length with a plain shift
  always_ff @(posedge Clk) begin
    if (SampleValid && lastSample && !Flush)
      Average <= sum[AccWidth-1:AvgLog2];
  end

endmodule

/* rtl/adcCapture.sv */
// ================================================
// Converter word capture
// Latches a word on Strobe, clamps out-of-range words
// to the rail and keeps a saturating OTR count
// ================================================
`timescale 1ns/1ps

module adcCapture import adcPkg::*; (
  input  logic       Clk,
  input  logic       reset_n,
  input  logic       Strobe,       // From the sequencer
  input  adcSample_t Adc,          // Converter pins
  output adcSample_t Sample,       // Clamped word
  output logic       SampleValid,  // One cycle after Strobe
  output logic [7:0] OtrCount      // Out-of-range captures, sticks at 255
);

  adcSample_t clamped;

  // On OTR the MSB tells which rail was crossed
  always_comb begin
    clamped = Adc;
    if (Adc.otr) begin
      if (Adc.data[SampleWidth-1])
        clamped.data = '1;   // Above full scale
      else
        clamped.data = '0;   // Below zero scale
    end
  end

  // Payload, only meaningful with SampleValid
  always_ff @(posedge Clk) begin
    if (Strobe)
      Sample <= clamped;
  end

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      SampleValid <= 1'b0;
      OtrCount    <= '0;
    end else begin
      SampleValid <= Strobe;
      if (Strobe && Adc.otr && (OtrCount != 8'hFF))
        OtrCount <= OtrCount + 1'b1;
    end
  end

endmodule

/* rtl/adcClockGen.sv */
// ================================================
// Converter clock generator
// Divides Clk by ClkDivide while Run is high, parks
// the output low and the phase at zero otherwise
// ================================================
`timescale 1ns/1ps

module adcClockGen import adcPkg::*; (
  input  logic Clk,
  input  logic reset_n,
  input  logic Run,        // From the sequencer
  output logic AdcClk,     // To the converter CLK pin
  output logic ClockFall   // High in the cycle ending with AdcClk falling
);

  localparam int HalfPeriod = ClkDivide / 2;
  localparam int PhaseWidth = (HalfPeriod > 1) ? $clog2(HalfPeriod) : 1;

  logic [PhaseWidth-1:0] phase;  // Clocks since the last toggle

  // Toggle lands on phase zero, so the first edge after Run is a rise
  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      phase  <= '0;
      AdcClk <= 1'b0;
    end else if (!Run) begin
      phase  <= '0;   // Same phase on every restart
      AdcClk <= 1'b0;
    end else begin
      if (phase == '0)
        AdcClk <= ~AdcClk;
      phase <= (phase == PhaseWidth'(HalfPeriod - 1)) ? '0 : phase + 1'b1;
    end
  end

  assign ClockFall = Run && AdcClk && (phase == '0);

  // Once stopped the converter clock stays parked
  assert property (@(posedge Clk) disable iff (!reset_n)
    !Run ##1 !Run |=> $stable(AdcClk))
    else $error("AdcClk moved while stopped");

endmodule

/* rtl/adcSequencer.sv */
// ================================================
// ADC acquisition sequencer
// Runs the converter clock while Start is high, skips
// the pipeline fill and times one capture per period
// ================================================
`timescale 1ns/1ps

module adcSequencer import adcPkg::*; (
  input  logic Clk,
  input  logic reset_n,
  input  logic Start,          // Level, acquisition enable
  input  logic ClockFall,      // Cycle before AdcClk falls
  output logic ClockRun,       // Converter clock enable
  output logic CaptureStrobe,  // Latch the converter word
  output logic Flush           // Drop any partial average
);

  // One counter serves both the warm-up falls and the hold gap
  localparam int CntMax   = (AdcPipeDelay > ClkDivide) ? AdcPipeDelay : ClkDivide;
  localparam int CntWidth = $clog2(CntMax);

  adcState_e state, nextState;
  logic [CntWidth-1:0] count, nextCount;
  logic running;

  assign running       = (state != Idle);
  assign ClockRun      = running && Start;   // Drops in the same cycle Start is seen low
  assign Flush         = running && !Start;  // Single pulse, state is Idle next cycle
  assign CaptureStrobe = (state == Acquire) && ClockFall;

  always_comb begin
    nextState = state;
    nextCount = count;
    case (state)
      Idle: begin
        if (Start) begin
          nextState = Warmup;
          nextCount = '0;
        end
      end
      Warmup: begin
        // Words clocked out during these falls are pipeline fill
        if (ClockFall) begin
          if (count == CntWidth'(AdcPipeDelay - 1)) begin
            nextState = Hold;
            nextCount = '0;
          end else begin
            nextCount = count + 1'b1;
          end
        end
      end
      Hold: begin
        // Three cycles after a fall, the next one is a cycle away
        if (count == CntWidth'(ClkDivide - 2)) begin
          nextState = Acquire;
        end else begin
          nextCount = count + 1'b1;
        end
      end
      Acquire: begin
        if (ClockFall) begin
          nextState = Hold;
          nextCount = '0;
        end
      end
      default: nextState = Idle;
    endcase
    // Start low wins over everything else
    if (running && !Start) begin
      nextState = Idle;
      nextCount = '0;
    end
  end

  always_ff @(posedge Clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= Idle;
      count <= '0;
    end else begin
      state <= nextState;
      count <= nextCount;
    end
  end

  // Hold count lines Acquire up with the converter clock fall
  assert property (@(posedge Clk) disable iff (!reset_n)
    (state == Acquire) && Start |-> ClockFall)
    else $error("Acquire missed the AdcClk fall");

  assert property (@(posedge Clk) disable iff (!reset_n)
    !(Flush && CaptureStrobe))
    else $error("Flush and CaptureStrobe together");

endmodule

/* rtl/adcPkg.sv */
// ================================================
// ADC front end shared definitions
// Converter word layout, pipeline constants and the
// sequencer state encoding
// ================================================
package adcPkg;

  // Converter word width, AD9220 class part
  localparam int SampleWidth = 12;

  // Conversions in flight inside the converter pipeline
  localparam int AdcPipeDelay = 3;

  // System clocks per converter clock period
  localparam int ClkDivide = 4;

  // Sequencer states
  typedef enum logic [1:0] {
    Idle    = 2'b00,  // Converter clock stopped
    Warmup  = 2'b01,  // Pipeline still filling
    Acquire = 2'b10,  // Waiting on the falling edge that captures
    Hold    = 2'b11   // Gap between two capture edges
  } adcState_e;

  // One converter word as it comes off the pins
  typedef struct packed {
    logic                   otr;   // Out-of-range flag, active high
    logic [SampleWidth-1:0] data;  // Bit 11 is the MSB
  } adcSample_t;

endpackage
